// File: cache_ctrl.sv
`default_nettype none
`include "cache_defs.svh"

module cache_ctrl (
    input  wire logic                                            clk_i,
    input  wire logic                                            nreset_i,
    input  wire logic                                            cc_valid_i,
    input  wire cache_pkt_pkg::core_req_t                        cc_pkt_i,
    output logic                                                 cc_ready_o,
    output logic                                                 cc_valid_o,
    output cache_geom_pkg::word_t                                cc_rdata_o,
    output logic                                                 cb_valid_o,
    input  wire logic                                            cb_yumi_i,
    output cache_pkt_pkg::bus_req_t                              cb_pkt_o,
    input  wire logic                                            cb_valid_i,
    input  wire cache_geom_pkg::block_t                          cb_data_i,
    input  wire logic                                            init_done_i,
    input  wire cache_geom_pkg::tag_t [`CACHE_WAYS-1:0]          tag_rdata_i,
    input  wire cache_geom_pkg::block_state_t [`CACHE_WAYS-1:0]  state_rdata_i,
    input  wire cache_geom_pkg::block_t [`CACHE_WAYS-1:0]        data_rdata_i,
    output logic                                                 rd_en_o,
    output cache_geom_pkg::index_t                               index_o,
    output logic [`CACHE_WAYS-1:0]                               way_wr_o,
    output cache_geom_pkg::tag_t                                 wr_tag_o,
    output cache_geom_pkg::block_state_t                         wr_state_o,
    output cache_geom_pkg::block_t                               wr_data_o,
    output cache_geom_pkg::block_mask_t                          wr_mask_o,
    output logic                                                 lru_touch_o,
    output cache_geom_pkg::way_t                                 lru_way_o,
    input  wire cache_geom_pkg::way_t                            lru_way_i
);

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_write_back,
        s_fill_req,
        s_fill_wait
    } ctrl_state_t;

    ctrl_state_t                 state_r, state_n;
    cache_pkt_pkg::core_req_t    req_r;
    cache_geom_pkg::tag_t        req_tag, victim_tag_r;
    cache_geom_pkg::index_t      req_index;
    cache_geom_pkg::offset_t     req_offset;
    cache_geom_pkg::way_t        hit_way, free_way, pick_way, way_r, way_sel;
    cache_geom_pkg::block_t      victim_block_r, store_block, fill_block, rd_block;
    cache_geom_pkg::block_mask_t store_mask;
    logic [`CACHE_OFFSET_W-3:0]  word_sel;
    logic [`CACHE_WAYS-1:0]      hit;
    logic                        any_invalid, accept, done, update;

    assign {req_tag, req_index, req_offset} = req_r.addr;
    assign word_sel   = req_offset[`CACHE_OFFSET_W-1:2];
    assign cc_ready_o = (state_r == s_idle) && init_done_i;
    assign accept     = cc_valid_i && cc_ready_o;
    assign rd_en_o    = accept;
    assign index_o    = accept ? cc_pkt_i.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W] : req_index;

    // hit way, else first invalid way, else lru
    always_comb begin
        hit         = '0;
        hit_way     = '0;
        free_way    = '0;
        any_invalid = 1'b0;
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            hit[w] = (state_rdata_i[w] != cache_geom_pkg::s_invalid) && (tag_rdata_i[w] == req_tag);
            if (hit[w]) begin
                hit_way = cache_geom_pkg::way_t'(w);
            end
            if (state_rdata_i[w] == cache_geom_pkg::s_invalid) begin
                any_invalid = 1'b1;
                free_way    = cache_geom_pkg::way_t'(w);
            end
        end
        if (|hit) begin
            pick_way = hit_way;
        end else if (any_invalid) begin
            pick_way = free_way;
        end else begin
            pick_way = lru_way_i;
        end
    end

    assign way_sel = (state_r == s_lookup) ? pick_way : way_r;

    // store bytes placed in their word lane
    assign store_block = {`CACHE_BLOCK_WORDS{req_r.wdata}};
    assign store_mask  = req_r.we ? cache_geom_pkg::block_mask_t'(req_r.be) << {word_sel, 2'b00} : '0;

    always_comb begin
        for (int b = 0; b < `CACHE_BLOCK_WORDS*4; b++) begin
            fill_block[8*b +: 8] = store_mask[b] ? store_block[8*b +: 8] : cb_data_i[8*b +: 8];
        end
    end

    // response on a hit or on the fill beat
    assign done   = ((state_r == s_lookup) && (|hit)) || ((state_r == s_fill_wait) && cb_valid_i);
    assign update = done && (req_r.we || (state_r == s_fill_wait));

    assign way_wr_o    = {`CACHE_WAYS{update}} & (`CACHE_WAYS'(1) << way_sel);
    assign wr_tag_o    = req_tag;
    assign wr_state_o  = req_r.we ? cache_geom_pkg::s_dirty : cache_geom_pkg::s_clean;
    assign wr_data_o   = fill_block;
    assign wr_mask_o   = (state_r == s_fill_wait) ? '1 : store_mask;
    assign lru_touch_o = done;
    assign lru_way_o   = way_sel;

    assign rd_block   = (state_r == s_fill_wait) ? cb_data_i : data_rdata_i[way_sel];
    assign cc_valid_o = done;
    assign cc_rdata_o = req_r.we ? '0 : rd_block[32*word_sel +: 32];

    assign cb_valid_o = (state_r == s_write_back) || (state_r == s_fill_req);

    always_comb begin
        cb_pkt_o.op    = cache_pkt_pkg::op_load;
        cb_pkt_o.addr  = {req_tag, req_index, cache_geom_pkg::offset_t'(0)};
        cb_pkt_o.wdata = '0;
        if (state_r == s_write_back) begin
            cb_pkt_o.op    = cache_pkt_pkg::op_write_back;
            cb_pkt_o.addr  = {victim_tag_r, req_index, cache_geom_pkg::offset_t'(0)};
            cb_pkt_o.wdata = victim_block_r;
        end
    end

    always_comb begin
        state_n = state_r;
        case (state_r)
            s_idle: begin
                if (accept) begin
                    state_n = s_lookup;
                end
            end
            s_lookup: begin
                if (|hit) begin
                    state_n = s_idle;
                end else if (state_rdata_i[pick_way] == cache_geom_pkg::s_dirty) begin
                    state_n = s_write_back;
                end else begin
                    state_n = s_fill_req;
                end
            end
            s_write_back: begin
                if (cb_yumi_i) begin
                    state_n = s_fill_req;
                end
            end
            s_fill_req: begin
                if (cb_yumi_i) begin
                    state_n = s_fill_wait;
                end
            end
            s_fill_wait: begin
                if (cb_valid_i) begin
                    state_n = s_idle;
                end
            end
            default: state_n = s_idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            state_r <= s_idle;
        end else begin
            state_r <= state_n;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_r <= cc_pkt_i;
        end
        // victim kept for the write-back
        if (state_r == s_lookup) begin
            way_r          <= pick_way;
            victim_tag_r   <= tag_rdata_i[pick_way];
            victim_block_r <= data_rdata_i[pick_way];
        end
    end

endmodule

`default_nettype wire

// File: cache_data_array.sv
`default_nettype none
`include "cache_defs.svh"

module cache_data_array (
    input  wire logic                                 clk_i,
    input  wire logic                                 rd_en_i,
    input  wire cache_geom_pkg::index_t               index_i,
    input  wire logic [`CACHE_WAYS-1:0]               wr_i,
    input  wire cache_geom_pkg::block_t               wdata_i,
    input  wire cache_geom_pkg::block_mask_t          wmask_i,
    output cache_geom_pkg::block_t [`CACHE_WAYS-1:0]  rdata_o
);

    cache_geom_pkg::block_t data_mem [`CACHE_SETS][`CACHE_WAYS];

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (wr_i[w]) begin
                // byte lanes
                for (int b = 0; b < `CACHE_BLOCK_WORDS*4; b++) begin
                    if (wmask_i[b]) begin
                        data_mem[index_i][w][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                rdata_o[w] <= data_mem[index_i][w];
            end
        end
    end

endmodule

`default_nettype wire

// File: cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cache geometry
`define CACHE_SETS 8
`define CACHE_WAYS 2
`define CACHE_BLOCK_WORDS 4
`define CACHE_ADDR_W 32

// derived address field widths
`define CACHE_INDEX_W $clog2(`CACHE_SETS)
`define CACHE_OFFSET_W ($clog2(`CACHE_BLOCK_WORDS) + 2)
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

// way number width
`define CACHE_WAY_W $clog2(`CACHE_WAYS)

`endif

// File: cache_geom_pkg.sv
`default_nettype none
`include "cache_defs.svh"

package cache_geom_pkg;

    // address fields
    typedef logic [`CACHE_ADDR_W-1:0] addr_t;
    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

    // data
    typedef logic [31:0] word_t;
    typedef logic [`CACHE_BLOCK_WORDS*32-1:0] block_t;
    typedef logic [`CACHE_BLOCK_WORDS*4-1:0] block_mask_t;

    typedef logic [`CACHE_WAY_W-1:0] way_t;

    // no shared state, so dirty alone marks ownership
    typedef enum logic [1:0] {
        s_invalid,
        s_clean,
        s_dirty
    } block_state_t;

endpackage

`default_nettype wire

// File: cache_lru.sv
`default_nettype none
`include "cache_defs.svh"

module cache_lru (
    input  wire logic                   clk_i,
    input  wire logic                   nreset_i,
    input  wire logic                   touch_i,
    input  wire cache_geom_pkg::index_t index_i,
    input  wire cache_geom_pkg::way_t   way_i,
    output cache_geom_pkg::way_t        lru_way_o
);

    // names the least recently used way of each set
    cache_geom_pkg::way_t lru_r [`CACHE_SETS];

    assign lru_way_o = lru_r[index_i];

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                lru_r[s] <= '0;
            end
        end else if (touch_i) begin
            // two ways, so the other one becomes lru
            lru_r[index_i] <= ~way_i;
        end
    end

endmodule

`default_nettype wire

// File: cache_pkt_pkg.sv
`default_nettype none
`include "cache_defs.svh"

package cache_pkt_pkg;

    typedef enum logic {
        op_load,
        op_write_back
    } bus_op_t;

    // core to cache
    typedef struct packed {
        logic                  we;
        logic [3:0]            be;
        cache_geom_pkg::addr_t addr;
        cache_geom_pkg::word_t wdata;
    } core_req_t;

    // cache to bus with one beat per block
    typedef struct packed {
        bus_op_t                op;
        cache_geom_pkg::addr_t  addr;
        cache_geom_pkg::block_t wdata;
    } bus_req_t;

endpackage

`default_nettype wire

// File: cache_tag_array.sv
`default_nettype none
`include "cache_defs.svh"

module cache_tag_array (
    input  wire logic                                       clk_i,
    input  wire logic                                       nreset_i,
    input  wire logic                                       rd_en_i,
    input  wire cache_geom_pkg::index_t                     index_i,
    input  wire logic [`CACHE_WAYS-1:0]                     wr_i,
    input  wire cache_geom_pkg::tag_t                       wr_tag_i,
    input  wire cache_geom_pkg::block_state_t               wr_state_i,
    output cache_geom_pkg::tag_t [`CACHE_WAYS-1:0]          tag_o,
    output cache_geom_pkg::block_state_t [`CACHE_WAYS-1:0]  state_o,
    output logic                                            init_done_o
);

    cache_geom_pkg::tag_t         tag_mem   [`CACHE_SETS][`CACHE_WAYS];
    cache_geom_pkg::block_state_t state_mem [`CACHE_SETS][`CACHE_WAYS];

    // one extra bit so the count can reach CACHE_SETS
    logic [`CACHE_INDEX_W:0] sweep_r;

    assign init_done_o = (sweep_r == `CACHE_SETS);

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            sweep_r <= '0;
        end else if (!init_done_o) begin
            sweep_r <= sweep_r + 1'b1;
        end
    end

    // invalidation sweep owns the state memory until done
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!init_done_o) begin
                state_mem[sweep_r[`CACHE_INDEX_W-1:0]][w] <= cache_geom_pkg::s_invalid;
            end else if (wr_i[w]) begin
                tag_mem[index_i][w]   <= wr_tag_i;
                state_mem[index_i][w] <= wr_state_i;
            end
        end
    end

    // registered read, holds between requests
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                tag_o[w]   <= tag_mem[index_i][w];
                state_o[w] <= state_mem[index_i][w];
            end
        end
    end

endmodule

`default_nettype wire

// File: cache_top.sv
`default_nettype none
`include "cache_defs.svh"

module cache_top (
    input  wire logic                     clk_i,
    input  wire logic                     nreset_i,
    input  wire logic                     cc_valid_i,
    input  wire cache_pkt_pkg::core_req_t cc_pkt_i,
    output logic                          cc_ready_o,
    output logic                          cc_valid_o,
    output cache_geom_pkg::word_t         cc_rdata_o,
    output logic                          cb_valid_o,
    input  wire logic                     cb_yumi_i,
    output cache_pkt_pkg::bus_req_t       cb_pkt_o,
    input  wire logic                     cb_valid_i,
    input  wire cache_geom_pkg::block_t   cb_data_i
);

    cache_geom_pkg::tag_t [`CACHE_WAYS-1:0]         tag_rdata;
    cache_geom_pkg::block_state_t [`CACHE_WAYS-1:0] state_rdata;
    cache_geom_pkg::block_t [`CACHE_WAYS-1:0]       data_rdata;
    cache_geom_pkg::index_t                         index;
    cache_geom_pkg::tag_t                           wr_tag;
    cache_geom_pkg::block_state_t                   wr_state;
    cache_geom_pkg::block_t                         wr_data;
    cache_geom_pkg::block_mask_t                    wr_mask;
    cache_geom_pkg::way_t                           touch_way, lru_way;
    logic [`CACHE_WAYS-1:0]                         way_wr;
    logic                                           rd_en, init_done, lru_touch;

    cache_ctrl u_ctrl (
        .clk_i, .nreset_i,
        .cc_valid_i, .cc_pkt_i, .cc_ready_o, .cc_valid_o, .cc_rdata_o,
        .cb_valid_o, .cb_yumi_i, .cb_pkt_o, .cb_valid_i, .cb_data_i,
        .init_done_i   (init_done),
        .tag_rdata_i   (tag_rdata),
        .state_rdata_i (state_rdata),
        .data_rdata_i  (data_rdata),
        .rd_en_o       (rd_en),
        .index_o       (index),
        .way_wr_o      (way_wr),
        .wr_tag_o      (wr_tag),
        .wr_state_o    (wr_state),
        .wr_data_o     (wr_data),
        .wr_mask_o     (wr_mask),
        .lru_touch_o   (lru_touch),
        .lru_way_o     (touch_way),
        .lru_way_i     (lru_way)
    );

    cache_tag_array u_tag_array (
        .clk_i, .nreset_i,
        .rd_en_i (rd_en), .index_i (index), .wr_i (way_wr),
        .wr_tag_i (wr_tag), .wr_state_i (wr_state),
        .tag_o (tag_rdata), .state_o (state_rdata), .init_done_o (init_done)
    );

    cache_data_array u_data_array (
        .clk_i,
        .rd_en_i (rd_en), .index_i (index), .wr_i (way_wr),
        .wdata_i (wr_data), .wmask_i (wr_mask), .rdata_o (data_rdata)
    );

    cache_lru u_lru (
        .clk_i, .nreset_i,
        .touch_i (lru_touch), .index_i (index), .way_i (touch_way), .lru_way_o (lru_way)
    );

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
cache_geom_pkg.sv
cache_pkt_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_lru.sv
cache_ctrl.sv
cache_top.sv
tb_clock_gen.sv
tb_cache.sv

// File: tb_cache.sv
`default_nettype none
`include "cache_defs.svh"

module tb_cache;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic                  we;
        logic [3:0]            be;
        cache_geom_pkg::addr_t addr;
        cache_geom_pkg::word_t wdata;
        logic                  exp_load;
    } stim_t;

    logic clk, nreset, cc_valid, cc_ready, cc_resp_valid;
    logic cb_req_valid, cb_yumi, cb_fill_valid, held;
    cache_pkt_pkg::core_req_t cc_pkt;
    cache_pkt_pkg::bus_req_t  cb_pkt, held_pkt;
    cache_geom_pkg::word_t    cc_rdata;
    cache_geom_pkg::block_t   cb_fill_data;
    cache_geom_pkg::addr_t    fill_addr;

    cache_geom_pkg::block_t   mem [cache_geom_pkg::addr_t];
    logic [7:0]               shadow [cache_geom_pkg::addr_t];
    cache_pkt_pkg::bus_req_t  bus_log [$];
    stim_t                    row_q [$];
    string                    name_q [$];
    string                    cur_name;

    logic [15:0] lfsr_r = 16'd23;
    int error_count = 0;
    int failed_rows = 0;
    int cycle_count = 0;
    int cycle_limit = 100000;
    int yumi_wait, fill_wait, low_cycles;
    logic fill_pending;

    tb_clock_gen u_clk (.clk_o (clk), .nreset_o (nreset));

    cache_top u_dut (
        .clk_i (clk), .nreset_i (nreset),
        .cc_valid_i (cc_valid), .cc_pkt_i (cc_pkt), .cc_ready_o (cc_ready),
        .cc_valid_o (cc_resp_valid), .cc_rdata_o (cc_rdata),
        .cb_valid_o (cb_req_valid), .cb_yumi_i (cb_yumi), .cb_pkt_o (cb_pkt),
        .cb_valid_i (cb_fill_valid), .cb_data_i (cb_fill_data)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_r = lfsr_step(lfsr_r);
            v = (v << 1) | lfsr_r[0];
        end
        return v;
    endfunction

    // untouched memory, every word mixes its full address
    function automatic cache_geom_pkg::block_t pattern_block(input cache_geom_pkg::addr_t a);
        cache_geom_pkg::block_t b;
        cache_geom_pkg::addr_t  wa;
        for (int i = 0; i < `CACHE_BLOCK_WORDS; i++) begin
            wa = a + 4 * i;
            b[32*i +: 32] = (wa * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
        end
        return b;
    endfunction

    function automatic cache_geom_pkg::block_t mem_read(input cache_geom_pkg::addr_t a);
        return mem.exists(a) ? mem[a] : pattern_block(a);
    endfunction

    function automatic logic [7:0] shadow_byte(input cache_geom_pkg::addr_t a);
        cache_geom_pkg::block_t blk;
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        blk = pattern_block({a[31:4], 4'b0000});
        return blk[8*a[3:0] +: 8];
    endfunction

    function automatic cache_geom_pkg::word_t shadow_word(input cache_geom_pkg::addr_t a);
        cache_geom_pkg::word_t w;
        for (int j = 0; j < 4; j++) begin
            w[8*j +: 8] = shadow_byte({a[31:2], 2'b00} + j);
        end
        return w;
    endfunction

    function automatic cache_geom_pkg::block_t shadow_block(input cache_geom_pkg::addr_t a);
        cache_geom_pkg::block_t b;
        for (int j = 0; j < `CACHE_BLOCK_WORDS * 4; j++) begin
            b[8*j +: 8] = shadow_byte(a + j);
        end
        return b;
    endfunction

    task automatic compare(input string name, input logic [191:0] exp_v,
                           input logic [191:0] act_v);
        if (exp_v !== act_v) begin
            error_count++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, exp_v, act_v);
        end
    endtask

    task automatic add_row(input string name, input logic we, input logic [3:0] be,
                           input cache_geom_pkg::addr_t addr,
                           input cache_geom_pkg::word_t wdata, input logic exp_load);
        name_q.push_back(name);
        row_q.push_back({we, be, addr, wdata, exp_load});
    endtask

    // memory model: random yumi, delayed fill, write-back into mem
    always @(posedge clk) begin
        cb_fill_valid <= 1'b0;
        if (nreset) begin
            cb_yumi <= 1'b0;
            yumi_wait = -1;
            fill_pending = 1'b0;
            held = 1'b0;
        end else begin
            if (fill_pending) begin
                if (fill_wait == 0) begin
                    cb_fill_valid <= 1'b1;
                    cb_fill_data  <= mem_read(fill_addr);
                    fill_pending = 1'b0;
                end else begin
                    fill_wait--;
                end
            end
            if (cb_req_valid && cb_yumi) begin
                bus_log.push_back(cb_pkt);
                cb_yumi <= 1'b0;
                yumi_wait = -1;
                held = 1'b0;
                if (cb_pkt.op == cache_pkt_pkg::op_write_back) begin
                    compare(cur_name, shadow_block(cb_pkt.addr), cb_pkt.wdata);
                    mem[cb_pkt.addr] = cb_pkt.wdata;
                end else begin
                    fill_pending = 1'b1;
                    fill_addr = cb_pkt.addr;
                    fill_wait = random_bits(2);
                end
            end else if (cb_req_valid) begin
                // request must hold while stalled
                if (held) begin
                    compare(cur_name, held_pkt, cb_pkt);
                end
                held = 1'b1;
                held_pkt = cb_pkt;
                if (yumi_wait < 0) begin
                    yumi_wait = random_bits(2);
                end
                if (yumi_wait == 0) begin
                    cb_yumi <= 1'b1;
                end else begin
                    yumi_wait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("ERROR: simulation hung without a response after %0d cycles", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic apply_row(input int idx);
        stim_t s;
        int cycles;
        int loads;
        int start_errors;
        cache_geom_pkg::addr_t blk_addr;
        cache_geom_pkg::word_t exp_word;
        s = row_q[idx];
        cur_name = name_q[idx];
        start_errors = error_count;
        blk_addr = {s.addr[31:4], 4'b0000};
        exp_word = s.we ? '0 : shadow_word(s.addr);
        bus_log.delete();
        cc_valid       <= 1'b1;
        cc_pkt.we      <= s.we;
        cc_pkt.be      <= s.be;
        cc_pkt.addr    <= s.addr;
        cc_pkt.wdata   <= s.wdata;
        @(posedge clk);
        while (!cc_ready) begin
            @(posedge clk);
        end
        cc_valid <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            compare(cur_name, 0, cc_ready);
        end while (!cc_resp_valid);
        compare(cur_name, exp_word, cc_rdata);
        loads = 0;
        foreach (bus_log[i]) begin
            if (bus_log[i].op == cache_pkt_pkg::op_load) begin
                loads++;
                compare(cur_name, blk_addr, bus_log[i].addr);
            end else begin
                // write-back goes out before the fill
                compare(cur_name, 0, i);
            end
        end
        compare(cur_name, s.exp_load, loads);
        if (!s.exp_load) begin
            compare(cur_name, 1, cycles);
        end
        if (s.we) begin
            for (int j = 0; j < 4; j++) begin
                if (s.be[j]) begin
                    shadow[{s.addr[31:2], 2'b00} + j] = s.wdata[8*j +: 8];
                end
            end
        end
        if (error_count != start_errors) begin
            failed_rows++;
        end
        $display("%-16s %s", cur_name, (error_count == start_errors) ? "pass" : "FAIL");
    endtask

    initial begin
        cc_valid      = 1'b0;
        cc_pkt        = '0;
        cb_yumi       = 1'b0;
        cb_fill_valid = 1'b0;
        cb_fill_data  = '0;
        cur_name      = "reset_sweep";

        add_row("load_miss",       1'b0, 4'hF, 32'h0000_0104, 32'h0000_0000, 1'b1);
        add_row("load_hit",        1'b0, 4'hF, 32'h0000_0108, 32'h0000_0000, 1'b0);
        add_row("store_hit_part",  1'b1, 4'h5, 32'h0000_0108, 32'hDEAD_BEEF, 1'b0);
        add_row("load_after_hit",  1'b0, 4'hF, 32'h0000_0108, 32'h0000_0000, 1'b0);
        add_row("store_miss_part", 1'b1, 4'hC, 32'h0000_0214, 32'h1234_5678, 1'b1);
        add_row("load_after_miss", 1'b0, 4'hF, 32'h0000_0214, 32'h0000_0000, 1'b0);
        add_row("dirty_a",         1'b1, 4'hF, 32'h0000_4030, 32'h1111_1111, 1'b1);
        add_row("dirty_b",         1'b1, 4'h3, 32'h0000_5034, 32'h2222_2222, 1'b1);
        add_row("dirty_c_evict",   1'b1, 4'h8, 32'h0000_6038, 32'h3333_3333, 1'b1);
        add_row("reload_evicted",  1'b0, 4'hF, 32'h0000_4030, 32'h0000_0000, 1'b1);
        add_row("lru_a",           1'b1, 4'hF, 32'h0000_1020, 32'hAAAA_0001, 1'b1);
        add_row("lru_b",           1'b1, 4'hF, 32'h0000_20A4, 32'hBBBB_0002, 1'b1);
        add_row("lru_touch_a",     1'b0, 4'hF, 32'h0000_1028, 32'h0000_0000, 1'b0);
        add_row("lru_c",           1'b0, 4'hF, 32'h0000_3120, 32'h0000_0000, 1'b1);
        add_row("lru_a_kept",      1'b0, 4'hF, 32'h0000_1020, 32'h0000_0000, 1'b0);
        add_row("lru_b_gone",      1'b0, 4'hF, 32'h0000_20A4, 32'h0000_0000, 1'b1);
        add_row("store_hit_full",  1'b1, 4'hF, 32'h0000_0100, 32'hCAFE_F00D, 1'b0);
        add_row("load_full",       1'b0, 4'hF, 32'h0000_0100, 32'h0000_0000, 1'b0);
        cycle_limit = row_q.size() * 20 + `CACHE_SETS + 4;

        // sweep keeps the core port closed
        @(posedge clk);
        while (nreset) begin
            @(posedge clk);
        end
        low_cycles = 0;
        while (!cc_ready) begin
            compare(cur_name, 0, cc_resp_valid);
            compare(cur_name, 0, cb_req_valid);
            low_cycles++;
            @(posedge clk);
        end
        compare(cur_name, 1, low_cycles >= `CACHE_SETS);
        $display("%-16s %s", cur_name, (error_count == 0) ? "pass" : "FAIL");
        if (error_count != 0) begin
            failed_rows++;
        end

        foreach (row_q[r]) begin
            apply_row(r);
        end

        $display("tests: %0d, failed: %0d, errors: %0d", row_q.size() + 1, failed_rows,
                 error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic nreset_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    initial begin
        nreset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        nreset_o <= 1'b0;
    end

endmodule

`default_nettype wire
